// ==== rtl/nn_pkg.sv ====
`default_nettype none

package nn_pkg;

	// single precision field layout.
	localparam int FP_EXP_BITS = 8;
	localparam int FP_MAN_BITS = 23;
	localparam int FP_BIAS = 127;

	localparam int N_INPUTS_DEF = 8;
	localparam int N_NEURONS_DEF = 4;

	typedef logic [31:0] word_t;

	// one row per neuron, element 0 first.
	localparam word_t WEIGHTS [N_NEURONS_DEF][N_INPUTS_DEF] = '{
		'{32'h3E19999A, 32'hBEB33333, 32'h3F0CCCCD, 32'hBE4CCCCD,
		  32'h3DCCCCCD, 32'hBF333333, 32'h3E99999A, 32'hBF4CCCCD},
		'{32'hBF19999A, 32'h3ECCCCCD, 32'hBE99999A, 32'h3F4CCCCD,
		  32'hBDCCCCCD, 32'h3F000000, 32'hBE800000, 32'h3F400000},
		'{32'h3F666666, 32'hBE000000, 32'h3E4CCCCD, 32'hBF000000,
		  32'h3EE66666, 32'hBECCCCCD, 32'h3F266666, 32'hBD4CCCCD},
		'{32'hBE19999A, 32'h3F59999A, 32'hBF400000, 32'h3E000000,
		  32'hBF266666, 32'h3F333333, 32'hBEE66666, 32'h3E800000}
	};

	localparam word_t BIASES [N_NEURONS_DEF] = '{
		32'h3DCCCCCD,
		32'hBE4CCCCD,
		32'h3E99999A,
		32'hBD4CCCCD
	};

endpackage

`default_nettype wire

// ==== rtl/fp_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mult (
	input  wire nn_pkg::word_t a,
	input  wire nn_pkg::word_t b,
	output nn_pkg::word_t      p
);

	import nn_pkg::*;

	localparam int MAN_W = FP_MAN_BITS + 1;
	localparam int PROD_W = 2 * MAN_W;
	localparam int EXP_W = FP_EXP_BITS + 2;
	localparam int EXP_LSB = FP_MAN_BITS;

	logic [FP_EXP_BITS-1:0] ea;
	logic [FP_EXP_BITS-1:0] eb;
	logic [MAN_W-1:0] ma;
	logic [MAN_W-1:0] mb;
	logic [PROD_W-1:0] prod;
	logic [FP_MAN_BITS-1:0] man;
	logic [EXP_W-1:0] exp_sum;
	logic sign;

	always_comb
	begin
		ea = a[EXP_LSB +: FP_EXP_BITS];
		eb = b[EXP_LSB +: FP_EXP_BITS];
		ma = {1'b1, a[FP_MAN_BITS-1:0]};
		mb = {1'b1, b[FP_MAN_BITS-1:0]};
		sign = a[31] ^ b[31];
		prod = ma * mb;

		// the product of two 1.x mantissas lies in [1, 4), so one shift at most.
		if (prod[PROD_W-1])
			man = prod[PROD_W-2 -: FP_MAN_BITS];
		else
			man = prod[PROD_W-3 -: FP_MAN_BITS];

		exp_sum = {2'b00, ea} + {2'b00, eb} - EXP_W'(FP_BIAS)
			+ {{(EXP_W-1){1'b0}}, prod[PROD_W-1]};

		if (ea == '0 || eb == '0)
			p = '0;
		else if (exp_sum[EXP_W-1] || exp_sum == '0)
			p = '0;
		else
			p = {sign, exp_sum[FP_EXP_BITS-1:0], man};
	end

endmodule

`default_nettype wire

// ==== rtl/fp_add.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_add (
	input  wire nn_pkg::word_t a,
	input  wire nn_pkg::word_t b,
	output nn_pkg::word_t      s
);

	import nn_pkg::*;

	localparam int MAN_W = FP_MAN_BITS + 1;
	localparam int EXP_W = FP_EXP_BITS + 2;
	localparam int MAG_W = FP_EXP_BITS + FP_MAN_BITS;
	localparam int LZ_W = $clog2(MAN_W);

	logic a_zero;
	logic b_zero;
	word_t big;
	word_t lesser;
	logic [FP_EXP_BITS-1:0] e_big;
	logic [FP_EXP_BITS-1:0] diff;
	logic [MAN_W-1:0] m_big;
	logic [MAN_W-1:0] m_small;
	logic [MAN_W:0] sum;
	logic [MAN_W-1:0] norm;
	logic [LZ_W-1:0] lz;
	logic [EXP_W-1:0] e_res;
	logic [FP_MAN_BITS-1:0] man;

	always_comb
	begin
		a_zero = (a[FP_MAN_BITS +: FP_EXP_BITS] == '0);
		b_zero = (b[FP_MAN_BITS +: FP_EXP_BITS] == '0);

		// sort by magnitude so the subtraction below never goes negative.
		if (a[MAG_W-1:0] >= b[MAG_W-1:0])
		begin
			big = a;
			lesser = b;
		end
		else
		begin
			big = b;
			lesser = a;
		end

		e_big = big[FP_MAN_BITS +: FP_EXP_BITS];
		diff = e_big - lesser[FP_MAN_BITS +: FP_EXP_BITS];
		m_big = {1'b1, big[FP_MAN_BITS-1:0]};
		m_small = {1'b1, lesser[FP_MAN_BITS-1:0]} >> diff;

		if (big[MAG_W] == lesser[MAG_W])
			sum = {1'b0, m_big} + {1'b0, m_small};
		else
			sum = {1'b0, m_big} - {1'b0, m_small};

		// leading zero count of the lower MAN_W bits; the highest set bit wins.
		lz = '0;
		for (int i = 0; i < MAN_W; i++)
		begin
			if (sum[i])
				lz = LZ_W'(MAN_W - 1 - i);
		end

		norm = sum[MAN_W-1:0] << lz;

		if (sum[MAN_W])
		begin
			man = sum[MAN_W-1:1];
			e_res = {2'b00, e_big} + 1'b1;
		end
		else
		begin
			man = norm[FP_MAN_BITS-1:0];
			e_res = {2'b00, e_big} - {{(EXP_W-LZ_W){1'b0}}, lz};
		end

		if (a_zero && b_zero)
			s = '0;
		else if (a_zero)
			s = b;
		else if (b_zero)
			s = a;
		else if (sum == '0)
			s = '0;
		else if (e_res[EXP_W-1] || e_res == '0)
			s = '0;
		else
			s = {big[MAG_W], e_res[FP_EXP_BITS-1:0], man};
	end

endmodule

`default_nettype wire

// ==== rtl/neuron.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuron #(
	parameter int N_INPUTS = nn_pkg::N_INPUTS_DEF,
	parameter int NEURON_INDEX = 0
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                start,
	input  wire nn_pkg::word_t x_vec [N_INPUTS],
	output nn_pkg::word_t      result,
	output logic               done
);

	import nn_pkg::*;

	localparam int IDX_W = (N_INPUTS > 1) ? $clog2(N_INPUTS) : 1;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_INPUTS - 1);

	logic busy;
	logic [IDX_W-1:0] idx;
	word_t acc;
	word_t weight;
	word_t product;
	word_t sum;

	assign weight = WEIGHTS[NEURON_INDEX][idx];

	fp_mult mult_inst (
		.a(x_vec[idx]),
		.b(weight),
		.p(product)
	);

	fp_add add_inst (
		.a(acc),
		.b(product),
		.s(sum)
	);

	// one term per busy cycle, element 0 first.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			idx <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				idx <= '0;
			end
			else if (busy)
			begin
				idx <= idx + 1'b1;
				if (idx == LAST_IDX)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			acc <= BIASES[NEURON_INDEX];
		else if (busy)
			acc <= sum;
	end

	// rectifier. a negative sum becomes +0.
	assign result = acc[31] ? '0 : acc;

endmodule

`default_nettype wire

// ==== rtl/input_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_loader #(
	parameter int N_INPUTS = nn_pkg::N_INPUTS_DEF
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                in_req,
	input  wire nn_pkg::word_t in_data,
	output logic               in_ack,
	input  wire                layer_free,
	output nn_pkg::word_t      x_vec [N_INPUTS],
	output logic               start
);

	import nn_pkg::*;

	localparam int CNT_W = (N_INPUTS > 1) ? $clog2(N_INPUTS) : 1;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(N_INPUTS - 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_ACK,
		S_FIRE,
		S_BUSY,
		S_HOLD
	} state_t;

	state_t state;
	logic [CNT_W-1:0] cnt;
	logic accept;

	assign accept = (state == S_IDLE) && in_req && layer_free;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			cnt <= '0;
			in_ack <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			case (state)
				S_IDLE:
					if (accept)
					begin
						in_ack <= 1'b1;
						state <= S_ACK;
					end
				S_ACK:
					if (!in_req)
					begin
						in_ack <= 1'b0;
						if (cnt == LAST_CNT)
						begin
							cnt <= '0;
							state <= S_FIRE;
						end
						else
						begin
							cnt <= cnt + 1'b1;
							state <= S_IDLE;
						end
					end
				S_FIRE:
				begin
					start <= 1'b1;
					state <= S_BUSY;
				end
				// wait for the drain to take the layer, then for it to let go.
				S_BUSY:
					if (!layer_free)
						state <= S_HOLD;
				S_HOLD:
					if (layer_free)
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			x_vec[cnt] <= in_data;
	end

endmodule

`default_nettype wire

// ==== rtl/output_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_drain #(
	parameter int N_NEURONS = nn_pkg::N_NEURONS_DEF
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire nn_pkg::word_t    results [N_NEURONS],
	input  wire [N_NEURONS-1:0]   done,
	output logic                  layer_free,
	output logic                  out_req,
	output nn_pkg::word_t         out_data,
	input  wire                   out_ack
);

	import nn_pkg::*;

	localparam int IDX_W = (N_NEURONS > 1) ? $clog2(N_NEURONS) : 1;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_NEURONS - 1);

	typedef enum logic [1:0] {
		S_COLLECT,
		S_LOAD,
		S_REQ,
		S_RELEASE
	} state_t;

	state_t state;
	logic [N_NEURONS-1:0] flags;
	logic [IDX_W-1:0] idx;

	// the results stay put until the next start, which cannot come before layer_free.
	assign out_data = results[idx];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= S_COLLECT;
			flags <= '0;
			idx <= '0;
			layer_free <= 1'b1;
			out_req <= 1'b0;
		end
		else
		begin
			case (state)
				S_COLLECT:
				begin
					flags <= flags | done;
					if (&flags)
					begin
						layer_free <= 1'b0;
						state <= S_LOAD;
					end
				end
				S_LOAD:
				begin
					out_req <= 1'b1;
					state <= S_REQ;
				end
				S_REQ:
					if (out_ack)
					begin
						out_req <= 1'b0;
						state <= S_RELEASE;
					end
				S_RELEASE:
					if (!out_ack)
					begin
						if (idx == LAST_IDX)
						begin
							idx <= '0;
							flags <= '0;
							layer_free <= 1'b1;
							state <= S_COLLECT;
						end
						else
						begin
							idx <= idx + 1'b1;
							out_req <= 1'b1;
							state <= S_REQ;
						end
					end
				default:
					state <= S_COLLECT;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dense_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dense_layer #(
	parameter int N_INPUTS = nn_pkg::N_INPUTS_DEF,
	parameter int N_NEURONS = nn_pkg::N_NEURONS_DEF
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                in_req,
	input  wire nn_pkg::word_t in_data,
	output logic               in_ack,
	output logic               out_req,
	output nn_pkg::word_t      out_data,
	input  wire                out_ack
);

	import nn_pkg::*;

	wire word_t x_vec [N_INPUTS];
	wire word_t results [N_NEURONS];
	wire [N_NEURONS-1:0] done;
	wire start;
	wire layer_free;

	input_loader #(
		.N_INPUTS(N_INPUTS)
	) input_loader_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(in_req),
		.in_data(in_data),
		.in_ack(in_ack),
		.layer_free(layer_free),
		.x_vec(x_vec),
		.start(start)
	);

	// all neurons see the same vector and start together.
	for (genvar g = 0; g < N_NEURONS; g++)
	begin : g_neuron
		neuron #(
			.N_INPUTS(N_INPUTS),
			.NEURON_INDEX(g)
		) neuron_inst (
			.clk(clk),
			.rst_n(rst_n),
			.start(start),
			.x_vec(x_vec),
			.result(results[g]),
			.done(done[g])
		);
	end

	output_drain #(
		.N_NEURONS(N_NEURONS)
	) output_drain_inst (
		.clk(clk),
		.rst_n(rst_n),
		.results(results),
		.done(done),
		.layer_free(layer_free),
		.out_req(out_req),
		.out_data(out_data),
		.out_ack(out_ack)
	);

endmodule

`default_nettype wire

// ==== verification/layer_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_checker #(
	parameter int N_INPUTS = nn_pkg::N_INPUTS_DEF,
	parameter int N_NEURONS = nn_pkg::N_NEURONS_DEF
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                in_req,
	input  wire nn_pkg::word_t in_data,
	input  wire                in_ack,
	input  wire                out_req,
	input  wire nn_pkg::word_t out_data,
	input  wire                out_ack,
	output int                 mismatches,
	output int                 protocol_errors,
	output int                 words_out,
	output int                 pending
);

	import nn_pkg::*;

	logic rst_q;
	logic in_req_q;
	logic in_ack_q;
	logic out_req_q;
	logic out_ack_q;
	word_t out_data_q;
	word_t in_buf [N_INPUTS];
	int in_cnt;
	word_t exp_q [$];

	// truncating multiply, zero exponent fields count as zero.
	function automatic word_t ref_mult(input word_t a, input word_t b);
		logic [47:0] prod;
		logic [22:0] frac;
		int e;
		if (a[30:23] == 8'd0 || b[30:23] == 8'd0)
			return '0;
		prod = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
		e = int'(a[30:23]) + int'(b[30:23]) - FP_BIAS;
		if (prod[47])
		begin
			frac = prod[46:24];
			e = e + 1;
		end
		else
			frac = prod[45:23];
		if (e <= 0)
			return '0;
		return {a[31] ^ b[31], 8'(e), frac};
	endfunction

	function automatic word_t ref_add(input word_t a, input word_t b);
		word_t big;
		word_t lesser;
		logic [24:0] mb;
		logic [24:0] ms;
		logic [24:0] total;
		int e;
		if (a[30:23] == 8'd0 && b[30:23] == 8'd0)
			return '0;
		if (a[30:23] == 8'd0)
			return b;
		if (b[30:23] == 8'd0)
			return a;
		if (a[30:0] >= b[30:0])
		begin
			big = a;
			lesser = b;
		end
		else
		begin
			big = b;
			lesser = a;
		end
		mb = {2'b01, big[22:0]};
		ms = {2'b01, lesser[22:0]} >> (int'(big[30:23]) - int'(lesser[30:23]));
		if (big[31] == lesser[31])
			total = mb + ms;
		else
			total = mb - ms;
		if (total == 25'd0)
			return '0;
		e = int'(big[30:23]);
		if (total[24])
		begin
			total = total >> 1;
			e = e + 1;
		end
		else
		begin
			while (!total[23])
			begin
				total = total << 1;
				e = e - 1;
			end
		end
		if (e <= 0)
			return '0;
		return {big[31], 8'(e), total[22:0]};
	endfunction

	function automatic word_t ref_neuron(input int n, input word_t x [N_INPUTS]);
		word_t acc;
		acc = BIASES[n];
		for (int i = 0; i < N_INPUTS; i++)
			acc = ref_add(acc, ref_mult(x[i], WEIGHTS[n][i]));
		// rectifier.
		if (acc[31])
			return '0;
		return acc;
	endfunction

	task automatic protocol_fail(input string what);
		$display("protocol error at %0t ns: %s", $time, what);
		protocol_errors = protocol_errors + 1;
	endtask

	// the DUT changes its outputs on an edge in answer to what it sampled there,
	// so each change is judged against the previous sample of the other signal.
	task automatic check_input_side();
		if (in_ack && !in_ack_q)
		begin
			if (!in_req_q)
				protocol_fail("in_ack rose while in_req was low");
			if (exp_q.size() != 0)
				protocol_fail("input word accepted while results were still draining");
			in_buf[in_cnt] = in_data;
			in_cnt = in_cnt + 1;
			if (in_cnt == N_INPUTS)
			begin
				for (int n = 0; n < N_NEURONS; n++)
					exp_q.push_back(ref_neuron(n, in_buf));
				in_cnt = 0;
			end
		end
		if (!in_ack && in_ack_q && in_req_q)
			protocol_fail("in_ack fell while in_req was still high");
	endtask

	task automatic check_output_side();
		word_t expected;
		if (out_req && !out_req_q && out_ack_q)
			protocol_fail("out_req rose before out_ack fell");
		if (!out_req && out_req_q && !out_ack_q)
			protocol_fail("out_req fell before out_ack rose");
		if (out_req && out_req_q && out_data !== out_data_q)
			protocol_fail("out_data changed while out_req was high");
		if (out_ack && !out_ack_q)
		begin
			if (exp_q.size() == 0)
				protocol_fail("output word arrived with no result pending");
			else
			begin
				expected = exp_q.pop_front();
				if (out_data !== expected)
				begin
					$display("mismatch at %0t ns: neuron %0d expected %h got %h",
						$time, words_out % N_NEURONS, expected, out_data);
					mismatches = mismatches + 1;
				end
			end
			words_out = words_out + 1;
		end
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			rst_q = 1'b0;
			in_req_q = 1'b0;
			in_ack_q = 1'b0;
			out_req_q = 1'b0;
			out_ack_q = 1'b0;
			out_data_q = '0;
			in_cnt = 0;
			mismatches = 0;
			protocol_errors = 0;
			words_out = 0;
			pending = 0;
		end
		else
		begin
			if (!rst_q && (in_ack || out_req))
				protocol_fail("in_ack or out_req was high right after reset");
			check_input_side();
			check_output_side();
			pending = exp_q.size();
			rst_q = 1'b1;
			in_req_q = in_req;
			in_ack_q = in_ack;
			out_req_q = out_req;
			out_ack_q = out_ack;
			out_data_q = out_data;
		end
	end

endmodule

`default_nettype wire

// ==== verification/tb_dense_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dense_layer;

	import nn_pkg::*;

	localparam int N_INPUTS = N_INPUTS_DEF;
	localparam int N_NEURONS = N_NEURONS_DEF;
	localparam int N_VEC = 11;
	// vectors from this index on see long out_ack delays.
	localparam int LONG_FROM = 8;
	localparam int WAIT_LIMIT = 1000;
	localparam int DRAIN_LIMIT = 5000;
	localparam logic [31:0] SEED = 32'h88ab5c27;

	logic clk;
	logic rst_n;
	logic in_req;
	word_t in_data;
	logic in_ack;
	logic out_req;
	word_t out_data;
	logic out_ack;

	int mismatches;
	int protocol_errors;
	int words_out;
	int pending;
	int timeouts;
	int other_errors;
	int vectors_sent;
	int ack_wait;
	word_t vectors [N_VEC][N_INPUTS];

	dense_layer #(
		.N_INPUTS(N_INPUTS),
		.N_NEURONS(N_NEURONS)
	) dense_layer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(in_req),
		.in_data(in_data),
		.in_ack(in_ack),
		.out_req(out_req),
		.out_data(out_data),
		.out_ack(out_ack)
	);

	layer_checker #(
		.N_INPUTS(N_INPUTS),
		.N_NEURONS(N_NEURONS)
	) layer_checker_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(in_req),
		.in_data(in_data),
		.in_ack(in_ack),
		.out_req(out_req),
		.out_data(out_data),
		.out_ack(out_ack),
		.mismatches(mismatches),
		.protocol_errors(protocol_errors),
		.words_out(words_out),
		.pending(pending)
	);

	always #5 clk = ~clk;

	// magnitude between 2^-4 and 2^4, random sign.
	function automatic word_t random_normal();
		logic sign;
		logic [7:0] e;
		logic [22:0] frac;
		sign = 1'($urandom % 2);
		e = 8'(123 + $urandom % 8);
		frac = 23'($urandom);
		return {sign, e, frac};
	endfunction

	function automatic word_t denormal_word();
		logic sign;
		logic [22:0] frac;
		sign = 1'($urandom % 2);
		frac = 23'($urandom | 1);
		return {sign, 8'h00, frac};
	endfunction

	task automatic build_vectors();
		for (int v = 0; v < N_VEC; v++)
			for (int i = 0; i < N_INPUTS; i++)
				vectors[v][i] = random_normal();
		for (int i = 0; i < N_INPUTS; i++)
		begin
			vectors[4][i] = '0;
			if (i % 3 == 1)
				vectors[5][i] = denormal_word();
			if (i % 2 == 0)
				vectors[6][i] = denormal_word();
			// every product of neuron 0 is negative, so its sum is too.
			vectors[7][i] = {~WEIGHTS[0][i][31], 8'd128, vectors[7][i][22:0]};
		end
		vectors[6][N_INPUTS-1] = 32'h8000_0000;
	endtask

	task automatic wait_in_ack(input logic level);
		int cycles;
		cycles = 0;
		while (in_ack !== level && cycles < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (in_ack !== level)
		begin
			$display("timeout at %0t ns: in_ack did not go to %0b", $time, level);
			timeouts++;
		end
	endtask

	task automatic send_word(input word_t w);
		in_data = w;
		in_req = 1'b1;
		wait_in_ack(1'b1);
		if (timeouts == 0)
		begin
			in_req = 1'b0;
			wait_in_ack(1'b0);
		end
	endtask

	task automatic send_vector(input int v);
		for (int i = 0; i < N_INPUTS && timeouts == 0; i++)
			send_word(vectors[v][i]);
		if (timeouts == 0)
			vectors_sent++;
	endtask

	task automatic wait_for_results(input int total);
		int cycles;
		cycles = 0;
		while (words_out < total && cycles < DRAIN_LIMIT)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (words_out < total)
		begin
			$display("timeout at %0t ns: only %0d of %0d results arrived",
				$time, words_out, total);
			timeouts++;
		end
	endtask

	// output sink with random ack delays.
	always @(posedge clk)
	begin
		#1;
		if (!rst_n)
			out_ack = 1'b0;
		else if (out_req && !out_ack)
		begin
			if (ack_wait > 0)
				ack_wait--;
			else
				out_ack = 1'b1;
		end
		else if (!out_req && out_ack)
		begin
			out_ack = 1'b0;
			if (words_out >= LONG_FROM * N_NEURONS)
				ack_wait = int'($urandom % 41);
			else
				ack_wait = int'($urandom % 4);
		end
	end

	initial
	begin
		void'($urandom(SEED));
		clk = 1'b0;
		rst_n = 1'b0;
		in_req = 1'b0;
		in_data = '0;
		out_ack = 1'b0;
		ack_wait = 0;
		timeouts = 0;
		other_errors = 0;
		vectors_sent = 0;
		build_vectors();
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// back to back, so later vectors wait on in_ack while results drain.
		for (int v = 0; v < N_VEC && timeouts == 0; v++)
			send_vector(v);
		if (timeouts == 0)
			wait_for_results(vectors_sent * N_NEURONS);
		repeat (20) @(posedge clk);
		if (timeouts == 0 && (pending != 0 || words_out != vectors_sent * N_NEURONS))
		begin
			$display("wrong output count: %0d words for %0d vectors", words_out, vectors_sent);
			other_errors++;
		end

		$display("mismatches %0d, protocol errors %0d, timeouts %0d, other errors %0d",
			mismatches, protocol_errors, timeouts, other_errors);
		if (mismatches + protocol_errors + timeouts + other_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/nn_pkg.sv
rtl/fp_mult.sv
rtl/fp_add.sv
rtl/neuron.sv
rtl/input_loader.sv
rtl/output_drain.sv
rtl/dense_layer.sv
verification/layer_checker.sv
verification/tb_dense_layer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the dense layer testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f filelist.f \
	--top-module tb_dense_layer -o tb_dense_layer
status=$?
if [ "$status" -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/tb_dense_layer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
	exit 0
fi
exit 1
